// ==== mipsCore.f ====
mipsPkg.sv
mainControl.sv
aluControl.sv
alu.sv
registerFile.sv
dataMemory.sv
instructionMemory.sv
mipsCore.sv
mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - mipsPkg.sv
  - mainControl.sv
  - aluControl.sv
  - alu.sv
  - registerFile.sv
  - dataMemory.sv
  - instructionMemory.sv
  - mipsCore.sv
  - target: test
    files:
      - mipsCoreTb.sv

// ==== mipsCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;

	import mipsPkg::*;

	localparam int dataWords    = 256;
	localparam int programWords = 256;
	localparam int resetCycles  = 5;

	// Expected trace of one retiring instruction
	typedef struct packed {
		logic [31:0] nextPc;
		logic        regWriteEn;
		logic [4:0]  writeReg;
		logic [31:0] writeData;
		logic        storeEn;
		logic [31:0] storeAddr;
		logic [31:0] storeData;
	} expectT;

	// Starts low without an edge at time zero
	logic        clk = 1'b0;
	logic        reset;
	logic        programWrite;
	logic [7:0]  programAddr;
	logic [31:0] programData;
	logic [31:0] pc;
	logic        regWriteEn;
	logic [4:0]  writeReg;
	logic [31:0] writeData;
	logic        storeEn;
	logic [31:0] storeAddr;
	logic [31:0] storeData;

	// Reference model state
	logic [31:0] programImage [$];
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [dataWords];
	logic [31:0] modelPc;
	expectT      expected;

	int retired;
	int retireTarget;
	int cycles;
	int checkCount;
	int mismatchCount;
	int timeoutCount;

	mipsCore #(.dataWords(dataWords), .programWords(programWords)) mipsCore_inst (
		.clk          (clk),
		.reset        (reset),
		.programWrite (programWrite),
		.programAddr  (programAddr),
		.programData  (programData),
		.pc           (pc),
		.regWriteEn   (regWriteEn),
		.writeReg     (writeReg),
		.writeData    (writeData),
		.storeEn      (storeEn),
		.storeAddr    (storeAddr),
		.storeData    (storeData)
	);

	initial
	begin
		forever #50 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] wanted);
		checkCount++;
		if (actual !== wanted)
		begin
			mismatchCount++;
			$display("ERROR %0t ns: %s is %h, expected %h", $time, name, actual, wanted);
		end
	endtask

	function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		programImage.push_back(word);
	endtask

	task automatic buildProgram();
		logic [31:0] rnd;
		logic [15:0] posImm;
		logic [15:0] negImm;
		logic [15:0] upperImm;
		logic [15:0] lowImm;
		rnd      = $urandom();
		posImm   = rnd[15:0] & 16'h7FFF;
		negImm   = rnd[31:16] | 16'h8000;
		rnd      = $urandom();
		upperImm = rnd[15:0] | 16'h8000;
		lowImm   = rnd[31:16] & 16'h7FFF;
		rnd      = $urandom();
		// Operands, r1 positive and r2 negative
		emit(encodeI(opAddi, 5'd0, 5'd1, posImm));
		emit(encodeI(opAddi, 5'd0, 5'd2, negImm));
		emit(encodeI(opAddi, 5'd1, 5'd3, 16'hFFFB));
		emit(encodeR(fnAdd, 5'd8, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnSub, 5'd9, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnAnd, 5'd10, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnOr, 5'd11, 5'd1, 5'd2, 5'd0));
		// Signed and unsigned compares disagree here
		emit(encodeR(fnSlt, 5'd12, 5'd2, 5'd1, 5'd0));
		emit(encodeR(fnSltu, 5'd13, 5'd2, 5'd1, 5'd0));
		emit(encodeR(fnSlt, 5'd14, 5'd1, 5'd3, 5'd0));
		emit(encodeR(fnSll, 5'd15, 5'd0, 5'd2, rnd[4:0]));
		emit(encodeR(fnSrl, 5'd16, 5'd0, 5'd2, rnd[9:5]));
		// Write to r0 is traced but dropped
		emit(encodeI(opAddi, 5'd1, 5'd0, 16'h0007));
		emit(encodeR(fnAdd, 5'd17, 5'd0, 5'd1, 5'd0));
		// Store word, negative upper half and positive lower half
		emit(encodeI(opAddi, 5'd0, 5'd5, upperImm));
		emit(encodeR(fnSll, 5'd5, 5'd0, 5'd5, 5'd16));
		emit(encodeI(opAddi, 5'd0, 5'd6, lowImm));
		emit(encodeR(fnOr, 5'd5, 5'd5, 5'd6, 5'd0));
		emit(encodeI(opAddi, 5'd0, 5'd20, 16'h0040));
		emit(encodeI(opSw, 5'd20, 5'd5, 16'h0008));
		emit(encodeI(opSw, 5'd20, 5'd8, 16'hFFFC));
		emit(encodeI(opLw, 5'd20, 5'd21, 16'h0008));
		emit(encodeI(opLh, 5'd20, 5'd22, 16'h0008));
		emit(encodeI(opLh, 5'd20, 5'd23, 16'h000A));
		emit(encodeI(opLhu, 5'd20, 5'd24, 16'h0008));
		emit(encodeI(opLhu, 5'd20, 5'd25, 16'h000A));
		emit(encodeI(opLw, 5'd20, 5'd26, 16'hFFFC));
		// Not taken, then taken over two addi
		emit(encodeI(opBeq, 5'd1, 5'd2, 16'h0002));
		emit(encodeI(opBeq, 5'd1, 5'd17, 16'h0002));
		emit(encodeI(opAddi, 5'd0, 5'd27, 16'h0001));
		emit(encodeI(opAddi, 5'd0, 5'd27, 16'h0002));
		emit({6'h3F, rnd[31:6]});
		emit(encodeR(fnAdd, 5'd28, 5'd27, 5'd23, 5'd0));
		// Self loop ends the program
		emit(encodeI(opBeq, 5'd0, 5'd0, 16'hFFFF));
	endtask

	// ISA model of the instruction at modelPc
	function automatic expectT predictStep();
		expectT      e;
		logic [31:0] instr;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] word;
		logic [15:0] half;
		instr = programImage[modelPc / 4];
		rsVal = modelRegs[instr[25:21]];
		rtVal = modelRegs[instr[20:16]];
		imm   = {{16{instr[15]}}, instr[15:0]};
		addr  = rsVal + imm;
		word  = modelMem[addr[9:2]];
		half  = addr[1] ? word[31:16] : word[15:0];
		e        = '0;
		e.nextPc = modelPc + 32'd4;
		case (instr[31:26])
			opRtype:
			begin
				e.regWriteEn = 1'b1;
				e.writeReg   = instr[15:11];
				case (instr[5:0])
					fnSub:   e.writeData = rsVal - rtVal;
					fnAnd:   e.writeData = rsVal & rtVal;
					fnOr:    e.writeData = rsVal | rtVal;
					fnSlt:   e.writeData = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
					fnSltu:  e.writeData = (rsVal < rtVal) ? 32'd1 : 32'd0;
					fnSll:   e.writeData = rtVal << instr[10:6];
					fnSrl:   e.writeData = rtVal >> instr[10:6];
					default: e.writeData = rsVal + rtVal;
				endcase
			end
			opAddi:
			begin
				e.regWriteEn = 1'b1;
				e.writeReg   = instr[20:16];
				e.writeData  = rsVal + imm;
			end
			opLw, opLh, opLhu:
			begin
				e.regWriteEn = 1'b1;
				e.writeReg   = instr[20:16];
				if (instr[31:26] == opLw)
					e.writeData = word;
				else if (instr[31:26] == opLh)
					e.writeData = {{16{half[15]}}, half};
				else
					e.writeData = {16'h0000, half};
			end
			opSw:
			begin
				e.storeEn   = 1'b1;
				e.storeAddr = addr;
				e.storeData = rtVal;
			end
			opBeq:
			begin
				if (rsVal == rtVal)
					e.nextPc = modelPc + 32'd4 + {imm[29:0], 2'b00};
			end
			// Unknown opcode retires as a no-op
			default:
				e.nextPc = modelPc + 32'd4;
		endcase
		return e;
	endfunction

	function automatic void applyStep(input expectT e);
		if (e.regWriteEn && e.writeReg != 5'd0)
			modelRegs[e.writeReg] = e.writeData;
		if (e.storeEn)
			modelMem[e.storeAddr[9:2]] = e.storeData;
		modelPc = e.nextPc;
	endfunction

	// Compare the trace in the middle of each cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			checkValue("regWriteEn in reset", regWriteEn, 1'b0);
			checkValue("storeEn in reset", storeEn, 1'b0);
		end
		else if (retired < retireTarget)
		begin
			expected = predictStep();
			checkValue("pc", pc, modelPc);
			checkValue("regWriteEn", regWriteEn, expected.regWriteEn);
			if (expected.regWriteEn)
			begin
				checkValue("writeReg", writeReg, expected.writeReg);
				checkValue("writeData", writeData, expected.writeData);
			end
			checkValue("storeEn", storeEn, expected.storeEn);
			if (expected.storeEn)
			begin
				checkValue("storeAddr", storeAddr, expected.storeAddr);
				checkValue("storeData", storeData, expected.storeData);
			end
			applyStep(expected);
			retired++;
		end
	end

	initial
	begin
		void'($urandom(32'h48ca9e1a));
		reset         = 1'b0;
		programWrite  = 1'b0;
		programAddr   = '0;
		programData   = '0;
		retired       = 0;
		checkCount    = 0;
		mismatchCount = 0;
		timeoutCount  = 0;
		modelPc       = '0;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		buildProgram();
		retireTarget = programImage.size() + 4;

		// Program goes in while the core is held in reset
		for (int i = 0; i < programImage.size(); i++)
		begin
			@(posedge clk);
			programWrite <= 1'b1;
			programAddr  <= i[7:0];
			programData  <= programImage[i];
		end
		@(posedge clk);
		programWrite <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b1;

		cycles = 0;
		while (retired < retireTarget && cycles < retireTarget * 2 + 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (retired < retireTarget)
		begin
			$display("Timeout: only %0d of %0d instructions retired", retired, retireTarget);
			timeoutCount++;
		end

		$display("Checks: %0d, mismatches: %0d, timeouts: %0d",
			checkCount, mismatchCount, timeoutCount);
		if (mismatchCount == 0 && timeoutCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
	parameter int dataWords    = 256,
	parameter int programWords = 256
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            programWrite,
	input  logic [$clog2(programWords)-1:0] programAddr,
	input  logic [mipsPkg::dataWidth-1:0]   programData,
	output logic [mipsPkg::dataWidth-1:0]   pc,
	output logic                            regWriteEn,
	output logic [4:0]                      writeReg,
	output logic [mipsPkg::dataWidth-1:0]   writeData,
	output logic                            storeEn,
	output logic [mipsPkg::dataWidth-1:0]   storeAddr,
	output logic [mipsPkg::dataWidth-1:0]   storeData
);

	import mipsPkg::*;

	logic [dataWidth-1:0] instruction;
	opcodeT               opcode;
	functT                funct;
	logic                 regDest;
	logic                 memRead;
	logic                 memToReg;
	logic                 memWrite;
	logic                 aluSrc;
	logic                 regWrite;
	logic                 branch;
	aluOpT                aluOp;
	loadKindT             loadKind;
	aluCtrlT              aluCtrl;
	logic [dataWidth-1:0] readData1;
	logic [dataWidth-1:0] readData2;
	logic [dataWidth-1:0] signExt;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic                 zero;
	logic [dataWidth-1:0] loadData;
	logic [dataWidth-1:0] pcPlus4;
	logic [dataWidth-1:0] branchTarget;

	// Instruction fields
	assign opcode  = opcodeT'(instruction[31:26]);
	assign funct   = functT'(instruction[5:0]);
	assign signExt = {{16{instruction[15]}}, instruction[15:0]};

	// Datapath muxes
	assign writeReg  = regDest ? instruction[15:11] : instruction[20:16];
	assign aluB      = aluSrc ? signExt : readData2;
	assign writeData = memToReg ? loadData : aluResult;

	// Next pc, branch offset counts words
	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {signExt[dataWidth-3:0], 2'b00};

	always_ff @(posedge clk)
	begin
		if (!reset)
			pc <= '0;
		else if (branch && zero)
			pc <= branchTarget;
		else
			pc <= pcPlus4;
	end

	// Trace of the retiring instruction
	assign regWriteEn = regWrite;
	assign storeEn    = memWrite;
	assign storeAddr  = aluResult;
	assign storeData  = readData2;

	instructionMemory #(.programWords(programWords)) instructionMemory_inst (
		.clk          (clk),
		.programWrite (programWrite && !reset),
		.programAddr  (programAddr),
		.programData  (programData),
		.pc           (pc),
		.instruction  (instruction)
	);

	mainControl mainControl_inst (
		.opcode   (opcode),
		.reset    (reset),
		.regDest  (regDest),
		.memRead  (memRead),
		.memToReg (memToReg),
		.memWrite (memWrite),
		.aluSrc   (aluSrc),
		.regWrite (regWrite),
		.branch   (branch),
		.aluOp    (aluOp),
		.loadKind (loadKind)
	);

	registerFile registerFile_inst (
		.clk       (clk),
		.reset     (reset),
		.readReg1  (instruction[25:21]),
		.readReg2  (instruction[20:16]),
		.writeReg  (writeReg),
		.writeEn   (regWrite),
		.writeData (writeData),
		.readData1 (readData1),
		.readData2 (readData2)
	);

	aluControl aluControl_inst (
		.aluOp   (aluOp),
		.funct   (funct),
		.aluCtrl (aluCtrl)
	);

	alu alu_inst (
		.a       (readData1),
		.b       (aluB),
		.shamt   (instruction[10:6]),
		.aluCtrl (aluCtrl),
		.result  (aluResult),
		.zero    (zero)
	);

	dataMemory #(.dataWords(dataWords)) dataMemory_inst (
		.clk       (clk),
		.addr      (aluResult),
		.writeData (readData2),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.loadKind  (loadKind),
		.readData  (loadData)
	);

endmodule

`default_nettype wire

// ==== instructionMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module instructionMemory #(
	parameter int programWords = 256
) (
	input  logic                            clk,
	input  logic                            programWrite,
	input  logic [$clog2(programWords)-1:0] programAddr,
	input  logic [mipsPkg::dataWidth-1:0]   programData,
	input  logic [mipsPkg::dataWidth-1:0]   pc,
	output logic [mipsPkg::dataWidth-1:0]   instruction
);

	import mipsPkg::*;

	localparam int indexBits = $clog2(programWords);

	logic [dataWidth-1:0] mem [programWords];

	// Program loaded one word per strobe
	always_ff @(posedge clk)
	begin
		if (programWrite)
			mem[programAddr] <= programData;
	end

	// Fetch by word index of the pc
	assign instruction = mem[pc[indexBits+1:2]];

endmodule

`default_nettype wire

// ==== dataMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module dataMemory #(
	parameter int dataWords = 256
) (
	input  logic                          clk,
	input  logic [mipsPkg::dataWidth-1:0] addr,
	input  logic [mipsPkg::dataWidth-1:0] writeData,
	input  logic                          memWrite,
	input  logic                          memRead,
	input  mipsPkg::loadKindT             loadKind,
	output logic [mipsPkg::dataWidth-1:0] readData
);

	import mipsPkg::*;

	localparam int indexBits = $clog2(dataWords);

	logic [dataWidth-1:0] mem [dataWords];
	logic [indexBits-1:0] wordIndex;
	logic [dataWidth-1:0] word;
	logic [15:0]          half;

	// Byte address to word index
	assign wordIndex = addr[indexBits+1:2];
	assign word      = mem[wordIndex];
	assign half      = addr[1] ? word[31:16] : word[15:0];

	always_ff @(posedge clk)
	begin
		if (memWrite)
			mem[wordIndex] <= writeData;
	end

	always_comb
	begin
		if (!memRead)
			readData = '0;
		else
		begin
			case (loadKind)
				loadHalf:         readData = {{16{half[15]}}, half};
				loadHalfUnsigned: readData = {16'h0000, half};
				default:          readData = word;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [4:0]                    readReg1,
	input  logic [4:0]                    readReg2,
	input  logic [4:0]                    writeReg,
	input  logic                          writeEn,
	input  logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readData1,
	output logic [mipsPkg::dataWidth-1:0] readData2
);

	import mipsPkg::*;

	logic [dataWidth-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		// Register 0 stays hardwired to zero
		else if (writeEn && (writeReg != 5'd0))
		begin
			regs[writeReg] <= writeData;
		end
	end

	// Asynchronous reads, old value on a same-cycle write
	assign readData1 = regs[readReg1];
	assign readData2 = regs[readReg2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	input  logic [4:0]                    shamt,
	input  mipsPkg::aluCtrlT              aluCtrl,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic                          zero
);

	import mipsPkg::*;

	always_comb
	begin
		case (aluCtrl)
			ctrlAdd:  result = a + b;
			ctrlSub:  result = a - b;
			ctrlAnd:  result = a & b;
			ctrlOr:   result = a | b;
			// Set on less than, signed then unsigned
			ctrlSlt:
				result = {{(dataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
			ctrlSltu:
				result = {{(dataWidth - 1){1'b0}}, a < b};
			// Shifts take rt and the shamt field
			ctrlSll:  result = b << shamt;
			ctrlSrl:  result = b >> shamt;
			default:  result = a + b;
		endcase
	end

	// Equal operands for beq
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== aluControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluControl (
	input  mipsPkg::aluOpT   aluOp,
	input  mipsPkg::functT   funct,
	output mipsPkg::aluCtrlT aluCtrl
);

	import mipsPkg::*;

	always_comb
	begin
		case (aluOp)
			aluSub:
				aluCtrl = ctrlSub;
			aluFunct:
			begin
				case (funct)
					fnAdd:   aluCtrl = ctrlAdd;
					fnSub:   aluCtrl = ctrlSub;
					fnAnd:   aluCtrl = ctrlAnd;
					fnOr:    aluCtrl = ctrlOr;
					fnSlt:   aluCtrl = ctrlSlt;
					fnSltu:  aluCtrl = ctrlSltu;
					fnSll:   aluCtrl = ctrlSll;
					fnSrl:   aluCtrl = ctrlSrl;
					// Unknown function falls back to add
					default: aluCtrl = ctrlAdd;
				endcase
			end
			default:
				aluCtrl = ctrlAdd;
		endcase
	end

endmodule

`default_nettype wire

// ==== mainControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module mainControl (
	input  mipsPkg::opcodeT   opcode,
	input  logic              reset,
	output logic              regDest,
	output logic              memRead,
	output logic              memToReg,
	output logic              memWrite,
	output logic              aluSrc,
	output logic              regWrite,
	output logic              branch,
	output mipsPkg::aluOpT    aluOp,
	output mipsPkg::loadKindT loadKind
);

	import mipsPkg::*;

	always_comb
	begin
		// Everything off unless the opcode turns it on
		regDest  = 1'b0;
		memRead  = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc   = 1'b0;
		regWrite = 1'b0;
		branch   = 1'b0;
		aluOp    = aluAdd;
		loadKind = loadWord;

		// Held in reset, the core sees a stream of no-ops
		if (reset)
		begin
			case (opcode)
				// add, sub, and, or, slt, sltu, sll, srl
				opRtype:
				begin
					regDest  = 1'b1;
					aluOp    = aluFunct;
					regWrite = 1'b1;
				end
				opAddi:
				begin
					aluSrc   = 1'b1;
					regWrite = 1'b1;
				end
				// Loads share the datapath, only the width differs
				opLw, opLh, opLhu:
				begin
					memRead  = 1'b1;
					memToReg = 1'b1;
					aluSrc   = 1'b1;
					regWrite = 1'b1;
					if (opcode == opLh)
						loadKind = loadHalf;
					else if (opcode == opLhu)
						loadKind = loadHalfUnsigned;
				end
				opSw:
				begin
					memWrite = 1'b1;
					aluSrc   = 1'b1;
				end
				// Compare rs and rt by subtraction
				opBeq:
				begin
					branch = 1'b1;
					aluOp  = aluSub;
				end
				default:
					regWrite = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// Width of the datapath and of byte addresses
	localparam int dataWidth = 32;

	// Primary opcode field, instruction bits 31:26
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLh    = 6'h21,
		opLw    = 6'h23,
		opLhu   = 6'h25,
		opSw    = 6'h2B
	} opcodeT;

	// Function field of R-type instructions, bits 5:0
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnAdd  = 6'h20,
		fnSub  = 6'h22,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2A,
		fnSltu = 6'h2B
	} functT;

	// ALU class chosen by the main decoder
	typedef enum logic [1:0] {
		aluAdd   = 2'b00,
		aluSub   = 2'b01,
		aluFunct = 2'b10
	} aluOpT;

	// Concrete operation performed by the ALU
	typedef enum logic [3:0] {
		ctrlAdd  = 4'd0,
		ctrlSub  = 4'd1,
		ctrlAnd  = 4'd2,
		ctrlOr   = 4'd3,
		ctrlSlt  = 4'd4,
		ctrlSltu = 4'd5,
		ctrlSll  = 4'd6,
		ctrlSrl  = 4'd7
	} aluCtrlT;

	// Load width and extension
	typedef enum logic [1:0] {
		loadWord         = 2'd0,
		loadHalf         = 2'd1,
		loadHalfUnsigned = 2'd2
	} loadKindT;

endpackage

`default_nettype wire
